//--- verilog/board_pkg.sv
/*
 * Board I/O constants, switch/header/I2C payload types
 * and the word addresses of the register port
 */
package board_pkg;

  localparam int unsigned NavSwWidth   = 5;
  localparam int unsigned UsrSwWidth   = 8;
  localparam int unsigned SelSwWidth   = 3;
  localparam int unsigned SwWidth      = SelSwWidth + UsrSwWidth + NavSwWidth;
  localparam int unsigned LedWidth     = 8;
  localparam int unsigned HdrWidth     = 11;
  localparam int unsigned I2cConnCount = 3;  // qwiic, header and click connectors

  localparam int unsigned RegAddrWidth = 4;
  localparam int unsigned RegDataWidth = 16;

  // Reset hold after lock, in clk_i edges
  localparam int unsigned RstHoldCycles = 16;
  localparam int unsigned RstCntWidth   = $clog2(RstHoldCycles + 1);
  localparam logic [RstCntWidth-1:0] RstCntLast = RstCntWidth'(RstHoldCycles - 1);

  localparam int unsigned SwStableCycles = 4;

  // Selection switches on top, joystick at the bottom
  typedef struct packed {
    logic [SelSwWidth-1:0] sel;
    logic [UsrSwWidth-1:0] usr;
    logic [NavSwWidth-1:0] nav;
  } sw_vec_t;

  typedef logic [HdrWidth-1:0] hdr_vec_t;

  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_lines_t;

  localparam logic [RegAddrWidth-1:0] RegLed     = 4'd0;
  localparam logic [RegAddrWidth-1:0] RegHdrOut  = 4'd1;
  localparam logic [RegAddrWidth-1:0] RegHdrOe   = 4'd2;
  localparam logic [RegAddrWidth-1:0] RegSwIn    = 4'd3;
  localparam logic [RegAddrWidth-1:0] RegHdrIn   = 4'd4;
  localparam logic [RegAddrWidth-1:0] RegEvent   = 4'd5;
  localparam logic [RegAddrWidth-1:0] RegI2cCtrl = 4'd6;
  localparam logic [RegAddrWidth-1:0] RegI2cIn   = 4'd7;

endpackage

//--- verilog/rst_ctrl.sv
/*
 * System reset sequencer. Holds the system reset low until the
 * board reset is released, the PLL is locked and a hold count expires
 */
`timescale 1ns/1ps

module rst_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,       // Board reset button, active low
  input  logic pll_locked_i,
  output logic rst_sys_n_o
);

  logic [board_pkg::RstCntWidth-1:0] hold_cnt_q;
  logic                              hold_clear;

  // Either source pulls the system back into reset
  assign hold_clear = !rst_n_i || !pll_locked_i;

  always_ff @(posedge clk_i) begin
    if (hold_clear) begin
      hold_cnt_q  <= '0;
      rst_sys_n_o <= 1'b0;
    end else if (!rst_sys_n_o) begin
      hold_cnt_q  <= hold_cnt_q + 1'b1;
      // Release on the edge where the count reaches RstHoldCycles
      rst_sys_n_o <= (hold_cnt_q == board_pkg::RstCntLast);
    end
  end

  // Loss of lock must be seen downstream on the very next cycle
  assert property (@(posedge clk_i) !pll_locked_i |=> !rst_sys_n_o)
    else $error("rst_ctrl: system reset high after PLL lock loss");

endmodule

//--- verilog/sync_debounce.sv
/*
 * Two-flop synchronizer followed by a stability filter,
 * shared by the switch, header and I2C input paths
 */
`timescale 1ns/1ps

module sync_debounce #(
  parameter type T            = logic,
  parameter int  StableCycles = 1
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  T     data_i,
  output T     data_o
);

  localparam int unsigned CntW = $clog2(StableCycles + 1);
  localparam logic [CntW-1:0] CntLimit = CntW'(StableCycles);

  T meta_q;
  T sync_q;
  T last_q;  // Synchronized value one cycle back

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
      last_q <= '0;
    end else begin
      meta_q <= data_i;
      sync_q <= meta_q;
      last_q <= sync_q;
    end
  end

  // Run length of the current synchronized value, saturating
  always_comb begin
    if (sync_q != last_q) begin
      cnt_d = CntW'(1);
    end else if (cnt_q != CntLimit) begin
      cnt_d = cnt_q + 1'b1;
    end else begin
      cnt_d = cnt_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      data_o <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (cnt_d == CntLimit) data_o <= sync_q;  // Held long enough
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(rst_n_i) && (data_o != $past(data_o))) |-> $past(cnt_d == CntLimit))
    else $error("sync_debounce: output changed before value was stable");

endmodule

//--- verilog/pad_mux.sv
/*
 * Pin-side logic: switch inversion, header output gating,
 * I2C open-drain fan-out and wired-AND read back
 */
`timescale 1ns/1ps

module pad_mux (
  input  board_pkg::sw_vec_t  sw_raw_i,
  output board_pkg::sw_vec_t  sw_pressed_o,

  input  board_pkg::hdr_vec_t hdr_out_i,
  input  board_pkg::hdr_vec_t hdr_oe_i,
  output board_pkg::hdr_vec_t hdr_o,
  output board_pkg::hdr_vec_t hdr_oe_o,

  input  logic [board_pkg::I2cConnCount-1:0] scl_low_i,
  input  logic [board_pkg::I2cConnCount-1:0] sda_low_i,
  output logic [board_pkg::I2cConnCount-1:0] i2c_scl_oe_o,
  output logic [board_pkg::I2cConnCount-1:0] i2c_sda_oe_o,

  input  logic [board_pkg::I2cConnCount-1:0] i2c_scl_i,
  input  logic [board_pkg::I2cConnCount-1:0] i2c_sda_i,
  output board_pkg::i2c_lines_t              i2c_in_o
);

  // Switches are pulled up and read 0 when pressed
  assign sw_pressed_o = ~sw_raw_i;

  // A released pin shows 0 on its data line
  assign hdr_o    = hdr_out_i & hdr_oe_i;
  assign hdr_oe_o = hdr_oe_i;

  // Open drain, the driven level is always 0 so only the enable leaves here
  assign i2c_scl_oe_o = scl_low_i;
  assign i2c_sda_oe_o = sda_low_i;

  // Any connector holding a line low pulls the whole bus low
  always_comb begin
    i2c_in_o.scl = &i2c_scl_i;
    i2c_in_o.sda = &i2c_sda_i;
  end

endmodule

//--- verilog/gpio_regs.sv
/*
 * Word-addressed register file: LEDs, header direction and data,
 * switch and I2C status, sticky switch event and its interrupt
 */
`timescale 1ns/1ps

module gpio_regs (
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic [board_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  logic [board_pkg::RegDataWidth-1:0] reg_wdata_i,
  input  logic                               reg_we_i,
  input  logic                               reg_re_i,
  output logic [board_pkg::RegDataWidth-1:0] reg_rdata_o,

  input  board_pkg::sw_vec_t    sw_i,      // Debounced, 1 = pressed
  input  board_pkg::hdr_vec_t   hdr_in_i,
  input  board_pkg::i2c_lines_t i2c_in_i,

  output logic [board_pkg::LedWidth-1:0]     led_o,
  output board_pkg::hdr_vec_t                hdr_out_o,
  output board_pkg::hdr_vec_t                hdr_oe_o,
  output logic [board_pkg::I2cConnCount-1:0] scl_low_o,
  output logic [board_pkg::I2cConnCount-1:0] sda_low_o,
  output logic                               irq_o
);

  logic [1:0]         i2c_ctrl_q;  // Bit 0 scl low, bit 1 sda low
  board_pkg::sw_vec_t sw_prev_q;
  logic               event_q;
  logic               sw_change;
  logic               event_clr;

  logic [board_pkg::RegDataWidth-1:0] rdata_d;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      led_o      <= '0;
      hdr_out_o  <= '0;
      hdr_oe_o   <= '0;
      i2c_ctrl_q <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        board_pkg::RegLed:     led_o      <= reg_wdata_i[board_pkg::LedWidth-1:0];
        board_pkg::RegHdrOut:  hdr_out_o  <= reg_wdata_i[board_pkg::HdrWidth-1:0];
        board_pkg::RegHdrOe:   hdr_oe_o   <= reg_wdata_i[board_pkg::HdrWidth-1:0];
        board_pkg::RegI2cCtrl: i2c_ctrl_q <= reg_wdata_i[1:0];
        default: ;  // Status and unknown addresses ignore writes
      endcase
    end
  end

  // Same pull-low request goes to every connector
  assign scl_low_o = {board_pkg::I2cConnCount{i2c_ctrl_q[0]}};
  assign sda_low_o = {board_pkg::I2cConnCount{i2c_ctrl_q[1]}};

  // Sticky switch event
  assign sw_change = (sw_i != sw_prev_q);
  assign event_clr = reg_we_i && (reg_addr_i == board_pkg::RegEvent) && reg_wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sw_prev_q <= '0;
      event_q   <= 1'b0;
    end else begin
      sw_prev_q <= sw_i;
      event_q   <= sw_change || (event_q && !event_clr);  // Set wins over clear
    end
  end

  assign irq_o = event_q;

  // Read mux sees register state before any write in the same cycle
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      board_pkg::RegLed:     rdata_d[board_pkg::LedWidth-1:0] = led_o;
      board_pkg::RegHdrOut:  rdata_d[board_pkg::HdrWidth-1:0] = hdr_out_o;
      board_pkg::RegHdrOe:   rdata_d[board_pkg::HdrWidth-1:0] = hdr_oe_o;
      board_pkg::RegSwIn:    rdata_d[board_pkg::SwWidth-1:0]  = sw_i;
      board_pkg::RegHdrIn:   rdata_d[board_pkg::HdrWidth-1:0] = hdr_in_i;
      board_pkg::RegEvent:   rdata_d[0]                       = event_q;
      board_pkg::RegI2cCtrl: rdata_d[1:0]                     = i2c_ctrl_q;
      board_pkg::RegI2cIn:   rdata_d[1:0]                     = i2c_in_i;
      default:               rdata_d = '0;
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (reg_we_i || reg_re_i) |-> !$isunknown(reg_addr_i))
    else $error("gpio_regs: strobe with unknown address");

endmodule

//--- verilog/board_top.sv
/*
 * Board I/O top level: reset sequencer, input filters,
 * pin logic and the register file
 */
`timescale 1ns/1ps

module board_top (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic pll_locked_i,

  input  board_pkg::sw_vec_t  sw_raw_i,  // Active low, pulled up

  input  board_pkg::hdr_vec_t hdr_i,
  output board_pkg::hdr_vec_t hdr_o,
  output board_pkg::hdr_vec_t hdr_oe_o,

  input  logic [board_pkg::I2cConnCount-1:0] i2c_scl_i,
  input  logic [board_pkg::I2cConnCount-1:0] i2c_sda_i,
  output logic [board_pkg::I2cConnCount-1:0] i2c_scl_oe_o,
  output logic [board_pkg::I2cConnCount-1:0] i2c_sda_oe_o,

  output logic [board_pkg::LedWidth-1:0] usr_led_o,
  output logic                           led_bootok_o,
  output logic                           irq_o,

  input  logic [board_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  logic [board_pkg::RegDataWidth-1:0] reg_wdata_i,
  input  logic                               reg_we_i,
  input  logic                               reg_re_i,
  output logic [board_pkg::RegDataWidth-1:0] reg_rdata_o
);

  logic                  sys_rst_n;
  board_pkg::sw_vec_t    sw_pressed;
  board_pkg::sw_vec_t    sw_db;
  board_pkg::hdr_vec_t   hdr_sync;
  board_pkg::hdr_vec_t   hdr_out;
  board_pkg::hdr_vec_t   hdr_oe;
  board_pkg::i2c_lines_t i2c_wired;
  board_pkg::i2c_lines_t i2c_sync;

  logic [board_pkg::I2cConnCount-1:0] scl_low;
  logic [board_pkg::I2cConnCount-1:0] sda_low;

  rst_ctrl u_rst_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pll_locked_i(pll_locked_i),
    .rst_sys_n_o (sys_rst_n)
  );

  assign led_bootok_o = sys_rst_n;  // Lit once the system is out of reset

  sync_debounce #(
    .T           (board_pkg::sw_vec_t),
    .StableCycles(board_pkg::SwStableCycles)
  ) u_sw_filter (
    .clk_i  (clk_i),
    .rst_n_i(sys_rst_n),
    .data_i (sw_pressed),
    .data_o (sw_db)
  );

  sync_debounce #(
    .T           (board_pkg::hdr_vec_t),
    .StableCycles(1)
  ) u_hdr_sync (
    .clk_i  (clk_i),
    .rst_n_i(sys_rst_n),
    .data_i (hdr_i),
    .data_o (hdr_sync)
  );

  // Bus is read back after the wired-AND, then synchronized
  sync_debounce #(
    .T           (board_pkg::i2c_lines_t),
    .StableCycles(1)
  ) u_i2c_sync (
    .clk_i  (clk_i),
    .rst_n_i(sys_rst_n),
    .data_i (i2c_wired),
    .data_o (i2c_sync)
  );

  pad_mux u_pad_mux (
    .sw_raw_i    (sw_raw_i),
    .sw_pressed_o(sw_pressed),
    .hdr_out_i   (hdr_out),
    .hdr_oe_i    (hdr_oe),
    .hdr_o       (hdr_o),
    .hdr_oe_o    (hdr_oe_o),
    .scl_low_i   (scl_low),
    .sda_low_i   (sda_low),
    .i2c_scl_oe_o(i2c_scl_oe_o),
    .i2c_sda_oe_o(i2c_sda_oe_o),
    .i2c_scl_i   (i2c_scl_i),
    .i2c_sda_i   (i2c_sda_i),
    .i2c_in_o    (i2c_wired)
  );

  gpio_regs u_gpio_regs (
    .clk_i      (clk_i),
    .rst_n_i    (sys_rst_n),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_we_i   (reg_we_i),
    .reg_re_i   (reg_re_i),
    .reg_rdata_o(reg_rdata_o),
    .sw_i       (sw_db),
    .hdr_in_i   (hdr_sync),
    .i2c_in_i   (i2c_sync),
    .led_o      (usr_led_o),
    .hdr_out_o  (hdr_out),
    .hdr_oe_o   (hdr_oe),
    .scl_low_o  (scl_low),
    .sda_low_o  (sda_low),
    .irq_o      (irq_o)
  );

endmodule

//--- dv/tb_board_top.sv
/*
 * Testbench for board_top, runs the operations of the vector file
 * through the register port and pins and checks the responses
 */
`timescale 1ns/1ps

module tb_board_top;

  localparam int VecDepth  = 64;
  localparam int WaitLimit = 400;  // Cycles per wait loop

  logic clk;
  logic rst_n;
  logic pll_locked;
  logic [board_pkg::SwWidth-1:0]      sw_raw;
  logic [board_pkg::HdrWidth-1:0]     hdr_in;
  logic [board_pkg::HdrWidth-1:0]     hdr_o;
  logic [board_pkg::HdrWidth-1:0]     hdr_oe;
  logic [board_pkg::I2cConnCount-1:0] scl_in;
  logic [board_pkg::I2cConnCount-1:0] sda_in;
  logic [board_pkg::I2cConnCount-1:0] scl_oe;
  logic [board_pkg::I2cConnCount-1:0] sda_oe;
  logic [board_pkg::LedWidth-1:0]     usr_led;
  logic                               led_bootok;
  logic                               irq;
  logic [board_pkg::RegAddrWidth-1:0] reg_addr;
  logic [board_pkg::RegDataWidth-1:0] reg_wdata;
  logic                               reg_we;
  logic                               reg_re;
  logic [board_pkg::RegDataWidth-1:0] reg_rdata;

  int checks = 0;
  int errors = 0;
  logic [39:0] vectors [VecDepth];  // op, sel, data, expect

  board_top DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .pll_locked_i(pll_locked),
    .sw_raw_i    (sw_raw),
    .hdr_i       (hdr_in),
    .hdr_o       (hdr_o),
    .hdr_oe_o    (hdr_oe),
    .i2c_scl_i   (scl_in),
    .i2c_sda_i   (sda_in),
    .i2c_scl_oe_o(scl_oe),
    .i2c_sda_oe_o(sda_oe),
    .usr_led_o   (usr_led),
    .led_bootok_o(led_bootok),
    .irq_o       (irq),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_rdata_o (reg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Output port by selector, zero extended
  function automatic logic [15:0] probe_port(input logic [3:0] sel, output string name);
    case (sel)
      4'd0:    begin name = "led_bootok_o"; probe_port = 16'(led_bootok); end
      4'd1:    begin name = "usr_led_o";    probe_port = 16'(usr_led);    end
      4'd2:    begin name = "hdr_o";        probe_port = 16'(hdr_o);      end
      4'd3:    begin name = "hdr_oe_o";     probe_port = 16'(hdr_oe);     end
      4'd4:    begin name = "irq_o";        probe_port = 16'(irq);        end
      4'd5:    begin name = "i2c_scl_oe_o"; probe_port = 16'(scl_oe);     end
      4'd6:    begin name = "i2c_sda_oe_o"; probe_port = 16'(sda_oe);     end
      default: begin name = "no port";      probe_port = 16'hDEAD;        end
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_we <= 1'b0;  // Captured on this edge
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [15:0] value);
    @(posedge clk);
    reg_re   <= 1'b1;
    reg_addr <= addr;
    @(posedge clk);
    reg_re <= 1'b0;
    @(negedge clk);  // Read data settled one cycle after the strobe
    value = reg_rdata;
  endtask

  // Repeated reads until the register holds the value
  task automatic poll_reg(input logic [3:0] addr, input logic [15:0] val);
    logic [15:0] value;
    int          tries;
    tries = 0;
    read_reg(addr, value);
    while (value !== val && tries < WaitLimit) begin
      read_reg(addr, value);
      tries++;
    end
    checks++;
    if (value !== val) begin
      $display("Register %0d never read %h, last value was %h", addr, val, value);
      errors++;
    end
  endtask

  // Cycle count 0 means the value is there right after the previous edge
  task automatic wait_port(input logic [3:0] sel, input logic [15:0] val,
                           input logic [15:0] exp_cycles);
    string       name;
    int          cycles;
    logic [15:0] value;
    cycles = 0;
    @(negedge clk);
    value = probe_port(sel, name);
    while (value !== val && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
      value = probe_port(sel, name);
    end
    checks++;
    if (value !== val) begin
      $display("Gave up waiting for %s to reach %h after %0d cycles", name, val, WaitLimit);
      errors++;
    end else if (exp_cycles != 16'hFFFF && cycles != int'(exp_cycles)) begin
      $display("MISMATCH at %0t: %s latency expected %0d got %0d",
               $time, name, exp_cycles, cycles);
      errors++;
    end
  endtask

  task automatic drive_pins(input logic [3:0] sel, input logic [15:0] data);
    @(posedge clk);
    case (sel)
      4'd0:    hdr_in <= data[board_pkg::HdrWidth-1:0];
      4'd1:    scl_in <= data[board_pkg::I2cConnCount-1:0];  // One bit per connector
      4'd2:    sda_in <= data[board_pkg::I2cConnCount-1:0];
      default: begin
        $display("Pin selector %0d does not exist", sel);
        errors++;
      end
    endcase
  endtask

  initial begin
    int          idx;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;
    bit          running;
    logic [3:0]  op;
    logic [3:0]  sel;
    logic [15:0] data;
    logic [15:0] expv;
    logic [15:0] value;

    rst_n      <= 1'b0;
    pll_locked <= 1'b1;
    sw_raw     <= '1;  // Released switches read high
    hdr_in     <= '0;
    scl_in     <= '1;  // Bus idles high
    sda_in     <= '1;
    reg_addr   <= '0;
    reg_wdata  <= '0;
    reg_we     <= 1'b0;
    reg_re     <= 1'b0;
    $readmemh("dv/board_vectors.mem", vectors);

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    idx       = 0;
    test_errs = 0;
    tests_ok  = 0;
    tests_bad = 0;
    running   = 1'b1;
    while (running && idx < VecDepth) begin
      {op, sel, data, expv} = vectors[idx];
      idx++;
      case (op)
        4'h0: running = 1'b0;
        4'h1: begin
          write_reg(sel, data);
          // Header direction shows on the pins from the next edge
          if (sel == board_pkg::RegHdrOe) begin
            @(negedge clk);
            check_value("hdr_oe_o", 16'(data[board_pkg::HdrWidth-1:0]), 16'(hdr_oe));
          end
        end
        4'h2: begin
          read_reg(sel, value);
          check_value($sformatf("reg_rdata_o of register %0d", sel), expv, value);
        end
        4'h3: begin
          @(posedge clk);
          sw_raw <= data;
        end
        4'h4: drive_pins(sel, data);
        4'h5: wait_port(sel, data, expv);
        4'h6: begin
          @(posedge clk);
          pll_locked <= data[0];
        end
        4'h7: repeat (int'(data)) @(posedge clk);
        4'h8: poll_reg(sel, data);
        4'hF: begin
          if (errors == test_errs) begin
            $display("test %0d: ok", sel);
            tests_ok++;
          end else begin
            $display("test %0d: %0d errors", sel, errors - test_errs);
            tests_bad++;
          end
          test_errs = errors;
        end
        default: begin
          $display("Vector %0d has unknown opcode %h", idx - 1, op);
          errors++;
        end
      endcase
    end

    $display("%0d tests ok, %0d tests with errors, %0d checks, %0d errors",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Overall limit on simulated time
  initial begin
    #400_000;
    $display("Simulation did not finish within 400 us");
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- dv/board_vectors.mem
// op_sel_data_expect. op 1 write, 2 read and compare, 3 raw switches, 4 pins (sel 0 header,
// 1 scl, 2 sda), 5 wait port (sel 0 bootok, 1 led, 2 hdr_o, 3 hdr_oe, 4 irq, 5 scl_oe,
// 6 sda_oe; expect = cycles, FFFF any), 6 pll lock, 7 idle, 8 poll register, F test end, 0 stop
5_0_0001_0010  // Reset release after 16 edges
1_0_00A5_0000
6_0_0000_0000
5_0_0000_0001
6_0_0001_0000
5_0_0001_0010
2_0_0000_0000
F_1_0000_0000
1_0_003C_0000  // Register access
5_1_003C_0000
1_1_FFA5_0000
1_2_0333_0000
2_0_0000_003C
2_1_0000_07A5
2_2_0000_0333
1_9_FFFF_0000
2_9_0000_0000
F_2_0000_0000
5_2_0321_FFFF  // Header data masked by enables
1_2_07FF_0000
5_2_07A5_0000
4_0_04C3_0000
8_4_04C3_0000
2_4_0000_04C3
F_3_0000_0000
3_0_7BDE_0000  // Switches pressed, read inverted
8_3_8421_0000
5_4_0001_FFFF
2_5_0000_0001
1_5_0001_0000
5_4_0000_0000
3_0_FFFF_0000  // Two cycle glitch
7_0_0001_0000
3_0_7BDE_0000
7_0_000A_0000
2_5_0000_0000
2_3_0000_8421
F_4_0000_0000
1_6_0001_0000  // I2C scl pull low
5_5_0007_0000
5_6_0000_0000
8_7_0003_0000
4_2_0005_0000
8_7_0002_0000
4_1_0003_0000
8_7_0000_0000
4_2_0007_0000
8_7_0001_0000
2_6_0000_0001
F_5_0000_0000
0_0_0000_0000

//--- filelist.f
verilog/board_pkg.sv
verilog/rst_ctrl.sv
verilog/sync_debounce.sv
verilog/pad_mux.sv
verilog/gpio_regs.sv
verilog/board_top.sv
dv/tb_board_top.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_board_top
	@out=$$(./obj_dir/Vtb_board_top); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

obj_dir/Vtb_board_top: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_board_top -f filelist.f

clean:
	rm -rf obj_dir
